//--- cpu.f
+incdir+rtl
rtl/rv32i_pkg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/hazard_ctrl_unit.sv
rtl/execute_stage.sv
rtl/mem_wb_stage.sv
rtl/cpu.sv
dv/tb_cpu.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu testbench, then judge the log
verilator --binary --timing --timescale 1ns/1ps -f cpu.f --top-module tb_cpu -o tb_cpu \
    || { echo "build failed"; exit 1; }
./obj_dir/tb_cpu > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || { echo "no result in sim.log"; exit 1; }
exit 0

//--- dv/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module tb_cpu
import rv32i_pkg::*;
();

    logic       clk;
    logic       rst_n;
    logic       imem_resp;
    logic       dmem_resp;
    rv32i_word  imem_rdata;
    rv32i_word  dmem_rdata;
    logic       imem_read;
    logic       dmem_read;
    logic       dmem_write;
    logic [3:0] dmem_wmask;
    rv32i_word  imem_address;
    rv32i_word  dmem_address;
    rv32i_word  dmem_wdata;

    rv32i_word imem [256];
    rv32i_word dmem [1024];
    rv32i_word got_addr [$];
    rv32i_word got_data [$];
    rv32i_word exp_addr [$];
    rv32i_word exp_data [$];
    int        seed = 63;
    int        prog_len;
    int        imem_wait;
    int        dmem_wait;
    logic      imem_pending;
    logic      dmem_pending;
    logic      done_seen;

    cpu dut (.*);

    always #50 clk = ~clk;

    // RV32I encodings with arguments in assembler order
    function automatic rv32i_word lui_instr(input int rd, input int imm);
        return {imm[19:0], rd[4:0], 7'b0110111};
    endfunction

    function automatic rv32i_word alu_imm_instr(input int f3, input int rd, input int rs1,
                                                input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0010011};
    endfunction

    function automatic rv32i_word alu_reg_instr(input int f7, input int f3, input int rd,
                                                input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic rv32i_word load_instr(input int rd, input int rs1, input int off);
        return {off[11:0], rs1[4:0], 3'b010, rd[4:0], 7'b0000011};
    endfunction

    function automatic rv32i_word store_instr(input int rs2, input int rs1, input int off);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], 7'b0100011};
    endfunction

    function automatic rv32i_word branch_instr(input int f3, input int rs1, input int rs2,
                                               input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    // odd multiplier keeps every address bit in play
    function automatic rv32i_word fill_word(input rv32i_word addr);
        return addr * 32'h9E37_79B1 + 32'h6A09_E667;
    endfunction

    // a response takes 1 to 4 cycles
    function automatic int response_delay();
        return $random(seed) & 3;
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input rv32i_word expected,
                              input rv32i_word actual);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t: %s expected %h got %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            report_failure($sformatf("error at %0t: %s expected %0d got %0d",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic check_mask(input string name, input logic [3:0] expected,
                              input logic [3:0] actual);
        if (actual !== expected) begin
            report_failure($sformatf("error at %0t: %s expected %h got %h",
                                     $time, name, expected, actual));
        end
    endtask

    task automatic record_store(input rv32i_word addr, input rv32i_word data);
        check_mask("dmem_wmask", 4'hF, dmem_wmask);
        if (addr == `CPU_DONE_ADDR) begin
            done_seen = 1'b1;
        end else begin
            got_addr.push_back(addr);
            got_data.push_back(data);
            dmem[addr[11:2]] = data;
        end
    endtask

    // instruction memory
    always @(posedge clk) begin
        #1;
        imem_resp = 1'b0;
        if (!rst_n) begin
            imem_pending = 1'b0;
        end else if (imem_read) begin
            if (!imem_pending) begin
                imem_pending = 1'b1;
                imem_wait    = response_delay();
            end
            if (imem_wait == 0) begin
                imem_resp    = 1'b1;
                imem_rdata   = imem[imem_address[9:2]];
                imem_pending = 1'b0;
            end else begin
                imem_wait--;
            end
        end
    end

    // data memory where writes land when answered
    always @(posedge clk) begin
        #1;
        dmem_resp = 1'b0;
        if (!rst_n) begin
            dmem_pending = 1'b0;
        end else if (dmem_read || dmem_write) begin
            if (!dmem_pending) begin
                dmem_pending = 1'b1;
                dmem_wait    = response_delay();
            end
            if (dmem_wait == 0) begin
                dmem_resp    = 1'b1;
                dmem_pending = 1'b0;
                if (dmem_write) begin
                    record_store(dmem_address, dmem_wdata);
                end else begin
                    dmem_rdata = dmem[dmem_address[11:2]];
                end
            end else begin
                dmem_wait--;
            end
        end
    end

    task automatic emit(input rv32i_word instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic expect_store(input rv32i_word addr, input rv32i_word data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // puts the core in reset and refills both memories
    task automatic start_program();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        prog_len = 0;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(i * 4);
        end
        for (int i = 0; i < 1024; i++) begin
            dmem[i] = fill_word(i * 4);
        end
    endtask

    task automatic check_stores();
        check_count("store count", exp_addr.size(), got_addr.size());
        for (int i = 0; i < exp_addr.size(); i++) begin
            check_word($sformatf("dmem_address[%0d]", i), exp_addr[i], got_addr[i]);
            check_word($sformatf("dmem_wdata[%0d]", i), exp_data[i], got_data[i]);
        end
    endtask

    task automatic run_program(input string name);
        rv32i_word done_addr;
        int        cycles;
        // store to the done address through x31 and then spin
        done_addr = `CPU_DONE_ADDR;
        emit(lui_instr(31, int'((done_addr + 32'h800) >> 12)));
        emit(alu_imm_instr(0, 31, 31, int'(done_addr)));
        emit(store_instr(0, 31, 0));
        emit(branch_instr(0, 0, 0, 0));
        repeat (10) @(posedge clk);
        #1;
        got_addr.delete();
        got_data.delete();
        done_seen = 1'b0;
        rst_n = 1'b1;
        cycles = 0;
        while (!done_seen && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        if (!done_seen) begin
            report_failure($sformatf("timeout: test %s never stored to the done address",
                                     name));
        end else begin
            check_stores();
        end
    endtask

    task automatic test_alu();
        rv32i_word a;
        rv32i_word b;
        a = 32'h1234_5678;
        b = 32'hFFFF_FEDD;
        start_program();
        emit(lui_instr(1, 'h12345));
        emit(alu_imm_instr(0, 1, 1, 'h678));
        emit(alu_imm_instr(0, 2, 0, -291));
        emit(alu_reg_instr(0, 0, 3, 1, 2));
        emit(alu_reg_instr('h20, 0, 4, 1, 2));
        emit(alu_reg_instr(0, 7, 5, 1, 2));
        emit(alu_reg_instr(0, 6, 6, 1, 2));
        emit(alu_reg_instr(0, 4, 7, 1, 2));
        emit(alu_reg_instr(0, 2, 8, 1, 2));
        emit(alu_reg_instr(0, 2, 9, 2, 1));
        emit(alu_imm_instr(7, 10, 1, 'h0F0));
        emit(alu_imm_instr(6, 11, 2, 'h005));
        emit(alu_imm_instr(4, 12, 1, -1));
        for (int r = 3; r <= 12; r++) begin
            emit(store_instr(r, 0, 'h100 + 4 * (r - 3)));
        end
        expect_store(32'h100, a + b);
        expect_store(32'h104, a - b);
        expect_store(32'h108, a & b);
        expect_store(32'h10C, a | b);
        expect_store(32'h110, a ^ b);
        expect_store(32'h114, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
        expect_store(32'h118, ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
        expect_store(32'h11C, a & 32'h0000_00F0);
        expect_store(32'h120, b | 32'h0000_0005);
        expect_store(32'h124, ~a);
        run_program("alu");
    endtask

    task automatic test_forwarding();
        rv32i_word r2;
        rv32i_word r4;
        rv32i_word r7;
        r2 = 32'd5 + 32'd3;
        r4 = r2 + 32'd5;
        r7 = r4 - 32'd1;
        start_program();
        emit(alu_imm_instr(0, 1, 0, 5));
        emit(alu_imm_instr(0, 2, 1, 3));
        emit(alu_imm_instr(0, 3, 0, 100));
        // x2 two back and x1 three back
        emit(alu_reg_instr(0, 0, 4, 2, 1));
        emit(alu_imm_instr(0, 5, 0, 1));
        emit(alu_imm_instr(0, 6, 0, 2));
        emit(alu_reg_instr('h20, 0, 7, 4, 5));
        emit(alu_reg_instr(0, 0, 8, 7, 7));
        emit(store_instr(8, 0, 'h200));
        emit(store_instr(2, 0, 'h204));
        emit(store_instr(4, 0, 'h208));
        emit(store_instr(7, 0, 'h20C));
        // base register one back
        emit(alu_imm_instr(0, 10, 0, 'h210));
        emit(store_instr(6, 10, 0));
        expect_store(32'h200, r7 + r7);
        expect_store(32'h204, r2);
        expect_store(32'h208, r4);
        expect_store(32'h20C, r7);
        expect_store(32'h210, 32'd2);
        run_program("forwarding");
    endtask

    task automatic test_load_use();
        rv32i_word v;
        v = 32'hABCD_E123;
        start_program();
        emit(lui_instr(1, 'hABCDE));
        emit(alu_imm_instr(0, 1, 1, 'h123));
        emit(store_instr(1, 0, 'h300));
        emit(load_instr(2, 0, 'h300));
        emit(alu_imm_instr(0, 3, 2, 77));
        emit(store_instr(3, 0, 'h304));
        // untouched word still holds the fill
        emit(load_instr(4, 0, 'h308));
        emit(alu_reg_instr('h20, 0, 5, 0, 4));
        emit(store_instr(5, 0, 'h30C));
        emit(load_instr(6, 0, 'h304));
        emit(store_instr(6, 0, 'h310));
        expect_store(32'h300, v);
        expect_store(32'h304, v + 32'd77);
        expect_store(32'h30C, 32'd0 - fill_word(32'h308));
        expect_store(32'h310, v + 32'd77);
        run_program("load_use");
    endtask

    task automatic test_branches();
        start_program();
        emit(alu_imm_instr(0, 1, 0, 1));
        emit(alu_imm_instr(0, 2, 0, 1));
        emit(branch_instr(0, 1, 2, 12));
        emit(store_instr(1, 0, 'h400));
        emit(store_instr(1, 0, 'h404));
        emit(store_instr(2, 0, 'h408));
        emit(branch_instr(1, 1, 2, 8));
        emit(store_instr(1, 0, 'h40C));
        emit(alu_imm_instr(0, 3, 0, 'h55));
        emit(store_instr(3, 0, 'h410));
        emit(branch_instr(0, 1, 3, 8));
        emit(store_instr(3, 0, 'h414));
        emit(branch_instr(1, 1, 3, 8));
        emit(store_instr(1, 0, 'h418));
        emit(store_instr(1, 0, 'h41C));
        expect_store(32'h408, 32'd1);
        expect_store(32'h40C, 32'd1);
        expect_store(32'h410, 32'h55);
        expect_store(32'h414, 32'h55);
        expect_store(32'h41C, 32'd1);
        run_program("branches");
    endtask

    task automatic test_back_pressure();
        rv32i_word addr;
        start_program();
        emit(alu_imm_instr(0, 1, 0, 0));
        emit(alu_imm_instr(0, 2, 0, 10));
        emit(alu_imm_instr(0, 3, 0, 'h500));
        emit(alu_imm_instr(0, 1, 1, 1));
        emit(store_instr(1, 3, 0));
        emit(load_instr(4, 3, 0));
        emit(alu_reg_instr(0, 0, 4, 4, 1));
        emit(store_instr(4, 3, 64));
        emit(alu_imm_instr(0, 3, 3, 4));
        emit(branch_instr(1, 1, 2, -24));
        for (int i = 1; i <= 10; i++) begin
            addr = 32'h500 + 32'(4 * (i - 1));
            expect_store(addr, 32'(i));
            expect_store(addr + 32'h40, 32'(2 * i));
        end
        run_program("back_pressure");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        imem_resp   = 1'b0;
        dmem_resp   = 1'b0;
        imem_rdata  = '0;
        dmem_rdata  = '0;
        done_seen   = 1'b0;
        test_alu();
        test_forwarding();
        test_load_use();
        test_branches();
        test_back_pressure();
        $display("Verification passed");
        $finish;
    end

endmodule : tb_cpu

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       imem_resp,
    input  logic       dmem_resp,
    input  rv32i_word  imem_rdata,
    input  rv32i_word  dmem_rdata,
    output logic       imem_read,
    output logic       dmem_read,
    output logic       dmem_write,
    output logic [3:0] dmem_wmask,
    output rv32i_word  imem_address,
    output rv32i_word  dmem_address,
    output rv32i_word  dmem_wdata
);

    // fetch -> decode
    logic       if_valid;
    rv32i_word  if_pc, if_instr;

    // decode <-> regfile
    logic [4:0] rs1_addr, rs2_addr;
    rv32i_word  rs1_data, rs2_data;

    // ID/EX
    logic       ex_valid, ex_use_imm, ex_is_branch, ex_branch_ne;
    logic       ex_mem_read, ex_mem_write, ex_reg_write;
    logic [4:0] ex_rs1, ex_rs2, ex_rd;
    rv32i_word  ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    alu_op_t    ex_alu_op;

    // EX/MEM
    logic       mem_valid, mem_mem_read, mem_mem_write, mem_reg_write;
    logic [4:0] mem_rd;
    rv32i_word  mem_result, mem_store_data;

    // MEM/WB
    logic       wb_valid, wb_reg_write;
    logic [4:0] wb_rd;
    rv32i_word  wb_data;

    // hazard control
    logic       stall_if_id, flush, freeze;
    logic       branch_taken, imem_busy, dmem_busy;
    rv32i_word  branch_target;
    fwd_sel_t   fwd_a_sel, fwd_b_sel;

    fetch_stage fetch_stage (.*);

    decode_stage decode_stage (.*);

    regfile regfile (
        .*,
        .wr_en   (wb_reg_write),
        .wr_addr (wb_rd),
        .wr_data (wb_data)
    );

    hazard_ctrl_unit hazard_ctrl_unit (
        .*,
        .id_rs1 (rs1_addr),
        .id_rs2 (rs2_addr)
    );

    execute_stage execute_stage (.*);

    mem_wb_stage mem_wb_stage (.*);

endmodule : cpu

`default_nettype wire

//--- rtl/mem_wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb_stage
import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       freeze,
    input  logic       mem_valid,
    input  logic [4:0] mem_rd,
    input  rv32i_word  mem_result,
    input  rv32i_word  mem_store_data,
    input  logic       mem_mem_read,
    input  logic       mem_mem_write,
    input  logic       mem_reg_write,
    input  logic       dmem_resp,
    input  rv32i_word  dmem_rdata,
    output logic       dmem_read,
    output logic       dmem_write,
    output logic [3:0] dmem_wmask,
    output rv32i_word  dmem_address,
    output rv32i_word  dmem_wdata,
    output logic       dmem_busy,
    output logic       wb_valid,
    output logic [4:0] wb_rd,
    output rv32i_word  wb_data,
    output logic       wb_reg_write
);

    logic      access_done;
    rv32i_word rdata_q;
    rv32i_word load_data;

    // one request per access, dropped once answered
    assign dmem_read    = mem_valid && mem_mem_read && !access_done;
    assign dmem_write   = mem_valid && mem_mem_write && !access_done;
    assign dmem_wmask   = 4'b1111;
    assign dmem_address = mem_result;
    assign dmem_wdata   = mem_store_data;
    assign dmem_busy    = (dmem_read || dmem_write) && !dmem_resp;
    assign load_data    = access_done ? rdata_q : dmem_rdata;

    // answered but fetch still waits, remember it
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            access_done <= 1'b0;
        end else if (!freeze) begin
            access_done <= 1'b0;
        end else if ((dmem_read || dmem_write) && dmem_resp) begin
            access_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_read && dmem_resp) begin
            rdata_q <= dmem_rdata;
        end
    end

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else if (!freeze) begin
            wb_valid     <= mem_valid;
            wb_reg_write <= mem_valid && mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            wb_rd   <= mem_rd;
            wb_data <= mem_mem_read ? load_data : mem_result;
        end
    end

endmodule : mem_wb_stage

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage
import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       freeze,
    input  logic       ex_valid,
    input  rv32i_word  ex_pc,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic [4:0] ex_rd,
    input  rv32i_word  ex_rs1_data,
    input  rv32i_word  ex_rs2_data,
    input  rv32i_word  ex_imm,
    input  alu_op_t    ex_alu_op,
    input  logic       ex_use_imm,
    input  logic       ex_is_branch,
    input  logic       ex_branch_ne,
    input  logic       ex_mem_read,
    input  logic       ex_mem_write,
    input  logic       ex_reg_write,
    input  fwd_sel_t   fwd_a_sel,
    input  fwd_sel_t   fwd_b_sel,
    input  rv32i_word  wb_data,
    output logic       branch_taken,
    output rv32i_word  branch_target,
    output logic       mem_valid,
    output logic [4:0] mem_rd,
    output rv32i_word  mem_result,
    output rv32i_word  mem_store_data,
    output logic       mem_mem_read,
    output logic       mem_mem_write,
    output logic       mem_reg_write
);

    rv32i_word op_a, op_b_reg, op_b, alu_out;

    function automatic rv32i_word fwd_mux(input fwd_sel_t sel, input rv32i_word rf_val,
                                          input rv32i_word mem_val, input rv32i_word wb_val);
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_a     = fwd_mux(fwd_a_sel, ex_rs1_data, mem_result, wb_data);
    assign op_b_reg = fwd_mux(fwd_b_sel, ex_rs2_data, mem_result, wb_data);
    assign op_b     = ex_use_imm ? ex_imm : op_b_reg;

    always_comb begin
        case (ex_alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // beq when equal, bne when not
    assign branch_taken  = ex_valid && ex_is_branch && ((op_a == op_b_reg) != ex_branch_ne);
    assign branch_target = ex_pc + ex_imm;

    // EX/MEM control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
            mem_reg_write <= 1'b0;
        end else if (!freeze) begin
            mem_valid     <= ex_valid;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
            mem_reg_write <= ex_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze) begin
            mem_rd         <= ex_rd;
            mem_result     <= alu_out;
            mem_store_data <= op_b_reg;
        end
    end

endmodule : execute_stage

`default_nettype wire

//--- rtl/hazard_ctrl_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl_unit
import rv32i_pkg::*;
(
    input  logic       ex_valid,
    input  logic       ex_mem_read,
    input  logic [4:0] ex_rd,
    input  logic [4:0] id_rs1,
    input  logic [4:0] id_rs2,
    input  logic       mem_valid,
    input  logic       mem_reg_write,
    input  logic [4:0] mem_rd,
    input  logic       wb_valid,
    input  logic       wb_reg_write,
    input  logic [4:0] wb_rd,
    input  logic [4:0] ex_rs1,
    input  logic [4:0] ex_rs2,
    input  logic       branch_taken,
    input  logic       imem_busy,
    input  logic       dmem_busy,
    output logic       stall_if_id,
    output logic       flush,
    output logic       freeze,
    output fwd_sel_t   fwd_a_sel,
    output fwd_sel_t   fwd_b_sel
);

    // youngest producer wins, x0 never forwards
    function automatic fwd_sel_t pick_src(input logic [4:0] rs);
        if (rs != 5'd0 && mem_valid && mem_reg_write && mem_rd == rs) begin
            return FWD_MEM;
        end else if (rs != 5'd0 && wb_valid && wb_reg_write && wb_rd == rs) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign fwd_a_sel = pick_src(ex_rs1);
    assign fwd_b_sel = pick_src(ex_rs2);

    // load result is not ready until it reaches writeback
    assign stall_if_id = ex_valid && ex_mem_read && ex_rd != 5'd0 &&
                         (ex_rd == id_rs1 || ex_rd == id_rs2);

    assign flush  = branch_taken;
    assign freeze = imem_busy || dmem_busy;

endmodule : hazard_ctrl_unit

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module decode_stage
import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall_if_id,
    input  logic       flush,
    input  logic       freeze,
    input  logic       if_valid,
    input  rv32i_word  if_pc,
    input  rv32i_word  if_instr,
    input  rv32i_word  rs1_data,
    input  rv32i_word  rs2_data,
    output logic [4:0] rs1_addr,
    output logic [4:0] rs2_addr,
    output logic       ex_valid,
    output rv32i_word  ex_pc,
    output logic [4:0] ex_rs1,
    output logic [4:0] ex_rs2,
    output logic [4:0] ex_rd,
    output rv32i_word  ex_rs1_data,
    output rv32i_word  ex_rs2_data,
    output rv32i_word  ex_imm,
    output alu_op_t    ex_alu_op,
    output logic       ex_use_imm,
    output logic       ex_is_branch,
    output logic       ex_branch_ne,
    output logic       ex_mem_read,
    output logic       ex_mem_write,
    output logic       ex_reg_write
);

    rv32i_opcode opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    rv32i_word   imm_i, imm_s, imm_b, imm_u;
    rv32i_word   imm;
    alu_op_t     alu_op;
    logic        legal, use_imm, is_branch, mem_read, mem_write, reg_write;
    logic        bubble;

    assign opcode   = rv32i_opcode'(if_instr[6:0]);
    assign funct3   = if_instr[14:12];
    assign funct7   = if_instr[31:25];
    assign rs1_addr = if_instr[19:15];
    assign rs2_addr = if_instr[24:20];

    assign imm_i = {{20{if_instr[31]}}, if_instr[31:20]};
    assign imm_s = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
    assign imm_b = {{19{if_instr[31]}}, if_instr[31], if_instr[7], if_instr[30:25],
                    if_instr[11:8], 1'b0};
    assign imm_u = {if_instr[31:12], 12'h000};

    always_comb begin
        legal     = 1'b1;
        alu_op    = ALU_ADD;
        imm       = imm_i;
        use_imm   = 1'b1;
        is_branch = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                imm       = imm_u;
                reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                reg_write = 1'b1;
                case (funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP: begin
                use_imm   = 1'b0;
                reg_write = 1'b1;
                // only sub carries a nonzero funct7
                legal     = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 == 3'b000);
                case (funct3)
                    3'b000:  alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu_op = ALU_SLT;
                    3'b100:  alu_op = ALU_XOR;
                    3'b110:  alu_op = ALU_OR;
                    3'b111:  alu_op = ALU_AND;
                    default: legal = 1'b0;
                endcase
            end
            OPC_LOAD: begin
                legal     = (funct3 == 3'b010);
                mem_read  = 1'b1;
                reg_write = 1'b1;
            end
            OPC_STORE: begin
                legal     = (funct3 == 3'b010);
                imm       = imm_s;
                mem_write = 1'b1;
            end
            OPC_BRANCH: begin
                // beq and bne only
                legal     = (funct3[2:1] == 2'b00);
                imm       = imm_b;
                use_imm   = 1'b0;
                is_branch = 1'b1;
            end
            default: legal = 1'b0;
        endcase
    end

    // nops need no slot downstream
    assign bubble = flush || stall_if_id || !if_valid || !legal || (if_instr == `CPU_NOP);

    // ID/EX control
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_is_branch <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
            ex_reg_write <= 1'b0;
        end else if (!freeze) begin
            ex_valid     <= !bubble;
            ex_is_branch <= is_branch && !bubble;
            ex_mem_read  <= mem_read && !bubble;
            ex_mem_write <= mem_write && !bubble;
            ex_reg_write <= reg_write && !bubble;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        if (!freeze) begin
            ex_pc        <= if_pc;
            ex_rs1       <= rs1_addr;
            ex_rs2       <= rs2_addr;
            ex_rd        <= if_instr[11:7];
            ex_rs1_data  <= rs1_data;
            ex_rs2_data  <= rs2_data;
            ex_imm       <= imm;
            ex_alu_op    <= alu_op;
            ex_use_imm   <= use_imm;
            ex_branch_ne <= funct3[0];
        end
    end

endmodule : decode_stage

`default_nettype wire

//--- rtl/regfile.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module regfile
import rv32i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [4:0] rs1_addr,
    input  logic [4:0] rs2_addr,
    input  logic       wr_en,
    input  logic [4:0] wr_addr,
    input  rv32i_word  wr_data,
    output rv32i_word  rs1_data,
    output rv32i_word  rs2_data
);

    rv32i_word regs [`CPU_NUM_REGS];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // x0 reads zero, a same-cycle write is passed straight through
    assign rs1_data = (rs1_addr == 5'd0) ? '0 :
                      (wr_en && wr_addr == rs1_addr) ? wr_data : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 :
                      (wr_en && wr_addr == rs2_addr) ? wr_data : regs[rs2_addr];

endmodule : regfile

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "cpu_defines.svh"

module fetch_stage
import rv32i_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall_if_id,
    input  logic      flush,
    input  logic      freeze,
    input  logic      branch_taken,
    input  rv32i_word branch_target,
    input  logic      imem_resp,
    input  rv32i_word imem_rdata,
    output logic      imem_read,
    output rv32i_word imem_address,
    output logic      imem_busy,
    output logic      if_valid,
    output rv32i_word if_pc,
    output rv32i_word if_instr
);

    fetch_state_t state;
    rv32i_word    fetch_pc;
    logic         skid_valid;
    rv32i_word    skid_instr;
    logic         have_word;
    rv32i_word    word;

    // a word is on hand either from the skid or straight off the bus
    assign have_word    = skid_valid || (state == FETCH_WAIT_RESP && imem_resp);
    assign word         = skid_valid ? skid_instr : imem_rdata;
    assign imem_busy    = !have_word;
    assign imem_read    = (state == FETCH_WAIT_RESP);
    assign imem_address = fetch_pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= FETCH_IDLE;
            fetch_pc   <= `CPU_RESET_PC;
            skid_valid <= 1'b0;
        end else if (!freeze) begin
            // not frozen, so the current word has arrived
            if (branch_taken) begin
                fetch_pc   <= branch_target;
                state      <= FETCH_WAIT_RESP;
                skid_valid <= 1'b0;
            end else if (stall_if_id) begin
                skid_valid <= 1'b1;
                state      <= FETCH_IDLE;
            end else begin
                fetch_pc   <= fetch_pc + 32'd4;
                state      <= FETCH_WAIT_RESP;
                skid_valid <= 1'b0;
            end
        end else if (state == FETCH_WAIT_RESP && imem_resp) begin
            // rest of the pipe is waiting, park the word
            skid_valid <= 1'b1;
            state      <= FETCH_IDLE;
        end else if (state == FETCH_IDLE && !skid_valid) begin
            state <= FETCH_WAIT_RESP;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_read && imem_resp) begin
            skid_instr <= imem_rdata;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
            if_instr <= `CPU_NOP;
        end else if (!freeze) begin
            if (flush) begin
                if_valid <= 1'b0;
                if_instr <= `CPU_NOP;
            end else if (!stall_if_id) begin
                if_valid <= 1'b1;
                if_instr <= word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!freeze && !stall_if_id) begin
            if_pc <= fetch_pc;
        end
    end

endmodule : fetch_stage

`default_nettype wire

//--- rtl/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } rv32i_opcode;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_t;

    // operand source in execute
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_MEM,
        FWD_WB
    } fwd_sel_t;

    typedef enum logic {
        FETCH_IDLE,
        FETCH_WAIT_RESP
    } fetch_state_t;

endpackage : rv32i_pkg

`default_nettype wire

//--- rtl/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// first instruction fetched after reset
`define CPU_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CPU_NOP 32'h0000_0013

`define CPU_NUM_REGS 32

// a store here marks the end of a test program
`define CPU_DONE_ADDR 32'h0000_0FFC

`endif
